// File: capture_pkg.sv
/* capture package: sample, word and counter widths, chirp and waveform latencies,
   route selects and the packed structs shared by the gate, framer and FIFO */
package capture_pkg;

  //////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////

  // one I or Q sample from the converters
  localparam int SAMPLE_W = 16;
  // one payload half, a packed I/Q pair or a counter
  localparam int HALF_W   = 32;
  // one captured word
  localparam int WORD_W   = 64;
  // latency down-counter
  localparam int LAT_W    = 8;

  //////////////////////////////////////////////////////////////
  // source latencies in clk_245_76MHz cycles
  //////////////////////////////////////////////////////////////

  // chirp source, same delay at both ends
  localparam logic [LAT_W-1:0] CHIRP_START_DELAY = LAT_W'(3);
  localparam logic [LAT_W-1:0] CHIRP_END_DELAY   = LAT_W'(3);
  // waveform source has a longer pipe in front of the DAC
  localparam logic [LAT_W-1:0] WFRM_START_DELAY  = LAT_W'(19);
  localparam logic [LAT_W-1:0] WFRM_END_DELAY    = LAT_W'(2);

  //////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////

  // i in the upper 16 bits, q in the lower
  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } iq_sample_t;

  // per-half source select
  typedef enum logic [1:0] {
    ROUTE_ADC        = 2'b00,
    ROUTE_DAC        = 2'b01,
    ROUTE_SAMPLE_CNT = 2'b10,
    ROUTE_GLOBAL_CNT = 2'b11
  } route_sel_e;

  typedef struct packed {
    route_sel_e upper;
    route_sel_e lower;
  } route_ctrl_t;

  // word plus frame markers, first on the header and last on the trailer
  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              first;
    logic              last;
  } capture_word_t;

  // gate to framer
  typedef struct packed {
    logic capture_on;
    logic start_frame;
    logic stop_frame;
  } gate_ctrl_t;

endpackage

// File: capture_gate.sv
/* capture gate: enable sync, source select latch, latency counter,
   capture enable with its start and stop pulses */
`timescale 1ns/1ps

module capture_gate (
  input  logic                    clk_245_76MHz,
  input  logic                    cpu_reset,
  input  logic                    chirp_init_i,
  input  logic                    adc_enable_i,
  input  logic                    wfrm_source_i,
  input  logic                    padding_i,
  output capture_pkg::gate_ctrl_t gate_o
);

  localparam logic [capture_pkg::LAT_W-1:0] LAT_ONE = 1;

  logic                          enable_r;
  logic                          capture_on;
  logic                          start_frame;
  logic                          wfrm_sel;
  logic [capture_pkg::LAT_W-1:0] lat_cnt;
  logic [capture_pkg::LAT_W-1:0] start_delay;
  logic [capture_pkg::LAT_W-1:0] end_delay;
  logic                          lat_zero;
  logic                          enable_fall;
  logic                          open_ok;

  // latencies for the latched source
  assign start_delay = wfrm_sel ? capture_pkg::WFRM_START_DELAY
                                : capture_pkg::CHIRP_START_DELAY;
  assign end_delay   = wfrm_sel ? capture_pkg::WFRM_END_DELAY
                                : capture_pkg::CHIRP_END_DELAY;

  assign lat_zero    = (lat_cnt == '0);
  // first low cycle of the raw enable after a high one
  assign enable_fall = enable_r & ~adc_enable_i;
  // capture_on may only move when idle and not padding
  assign open_ok     = lat_zero & ~padding_i;

  //////////////////////////////////////////////////////////////
  // enable sync and source select
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
    end
  end

  // source may only change between captures
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wfrm_sel <= 1'b0;
    end else if (!adc_enable_i) begin
      wfrm_sel <= wfrm_source_i;
    end
  end

  //////////////////////////////////////////////////////////////
  // latency counter
  //////////////////////////////////////////////////////////////

  // start has priority over the end load
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt <= '0;
    end else if (chirp_init_i) begin
      lat_cnt <= start_delay;
    end else if (enable_fall) begin
      lat_cnt <= end_delay;
    end else if (!lat_zero) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // capture_on follows the synced enable once the counter has drained
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      capture_on  <= 1'b0;
      start_frame <= 1'b0;
    end else begin
      // high in the first cycle with capture_on set
      start_frame <= open_ok & enable_r & ~capture_on;
      if (open_ok) begin
        capture_on <= enable_r;
      end
    end
  end

  always_comb begin
    gate_o.capture_on  = capture_on;
    gate_o.start_frame = start_frame;
    // one cycle ahead of the end countdown reaching zero
    gate_o.stop_frame  = (lat_cnt == LAT_ONE) & capture_on & ~enable_r;
  end

endmodule

// File: frame_builder.sv
/* frame builder: global, sample and in-frame counters, half routing,
   header and trailer words, alignment padding and the write strobe */
`timescale 1ns/1ps

module frame_builder #(
  // power of two, 2 or more
  parameter int ALIGN_WORDS = 64
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  capture_pkg::gate_ctrl_t    gate_i,
  input  capture_pkg::route_ctrl_t   route_ctrl_i,
  input  capture_pkg::iq_sample_t    adc_sample_i,
  input  capture_pkg::iq_sample_t    dac_sample_i,
  input  logic                       sample_valid_i,
  output capture_pkg::capture_word_t word_o,
  output logic                       word_wr_o,
  output logic                       padding_o
);

  localparam int FC_W  = $clog2(ALIGN_WORDS);
  localparam int PAD_W = FC_W + 1;

  capture_pkg::route_ctrl_t           route_q;
  logic [capture_pkg::HALF_W-1:0]     glbl_cnt;
  logic [capture_pkg::HALF_W-1:0]     sample_cnt;
  logic [FC_W-1:0]                    frame_cnt;
  logic [FC_W-1:0]                    frame_base;
  logic [FC_W-1:0]                    frame_next;
  logic [PAD_W-1:0]                   pad_cnt;
  logic [PAD_W-1:0]                   pad_load;
  logic                               hdr_pend;
  logic                               in_frame;
  logic                               hdr_now;
  logic                               frame_open;
  logic                               wr_en;
  logic                               is_hdr;
  logic                               is_trl;
  logic [capture_pkg::HALF_W-1:0]     upper_half;
  logic [capture_pkg::HALF_W-1:0]     lower_half;

  // one half of a payload word by its select
  function automatic logic [capture_pkg::HALF_W-1:0] route_half(
    input capture_pkg::route_sel_e       sel,
    input capture_pkg::iq_sample_t       adc,
    input capture_pkg::iq_sample_t       dac,
    input logic [capture_pkg::HALF_W-1:0] scnt,
    input logic [capture_pkg::HALF_W-1:0] gcnt
  );
    logic [capture_pkg::HALF_W-1:0] half;
    case (sel)
      capture_pkg::ROUTE_ADC:        half = adc;
      capture_pkg::ROUTE_DAC:        half = dac;
      capture_pkg::ROUTE_SAMPLE_CNT: half = scnt;
      default:                       half = gcnt;
    endcase
    return half;
  endfunction

  //////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////

  // frame opens with start_frame and closes after the trailer
  assign frame_open = gate_i.start_frame | in_frame;
  assign hdr_now    = gate_i.start_frame | hdr_pend;
  assign wr_en      = gate_i.capture_on & sample_valid_i & frame_open;
  assign is_hdr     = wr_en & hdr_now;
  // last pad slot is the trailer
  assign is_trl     = wr_en & (pad_cnt == PAD_W'(1));

  // words in frame after this cycle, mod ALIGN_WORDS
  assign frame_base = gate_i.start_frame ? '0 : frame_cnt;
  assign frame_next = frame_base + FC_W'(wr_en);
  // remaining words incl. trailer, a full block when already aligned
  assign pad_load   = PAD_W'(ALIGN_WORDS) - {1'b0, frame_next};
  assign padding_o  = (pad_cnt != '0);

  assign upper_half = route_half(route_q.upper, adc_sample_i, dac_sample_i,
                                 sample_cnt, glbl_cnt);
  assign lower_half = route_half(route_q.lower, adc_sample_i, dac_sample_i,
                                 sample_cnt, glbl_cnt);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_q    <= '{upper: capture_pkg::ROUTE_ADC, lower: capture_pkg::ROUTE_ADC};
      glbl_cnt   <= '0;
      sample_cnt <= '0;
      frame_cnt  <= '0;
      hdr_pend   <= 1'b0;
      in_frame   <= 1'b0;
      word_wr_o  <= 1'b0;
    end else begin
      route_q    <= route_ctrl_i;
      glbl_cnt   <= glbl_cnt + 1'b1;
      // written words, header and trailer included
      if (wr_en) begin
        sample_cnt <= sample_cnt + 1'b1;
      end
      frame_cnt  <= frame_next;
      hdr_pend   <= hdr_now & ~wr_en;
      in_frame   <= frame_open & ~is_trl;
      word_wr_o  <= wr_en;
    end
  end

  //////////////////////////////////////////////////////////////
  // alignment padding
  //////////////////////////////////////////////////////////////

  // counts written words down to the trailer
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      pad_cnt <= '0;
    end else if (gate_i.stop_frame) begin
      pad_cnt <= pad_load;
    end else if (wr_en && padding_o) begin
      pad_cnt <= pad_cnt - 1'b1;
    end
  end

  // header and trailer carry {global count, sample count}
  always_ff @(posedge clk_245_76MHz) begin
    if (wr_en) begin
      word_o.first <= is_hdr;
      word_o.last  <= is_trl;
      if (is_hdr || is_trl) begin
        word_o.data <= {glbl_cnt, sample_cnt};
      end else begin
        word_o.data <= {upper_half, lower_half};
      end
    end
  end

endmodule

// File: frame_fifo.sv
/* frame FIFO: circular word buffer, sink credit counter,
   credit-paced output and sticky overflow flag */
`timescale 1ns/1ps

module frame_fifo #(
  parameter int FIFO_DEPTH   = 256,
  parameter int SINK_CREDITS = 8
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  capture_pkg::capture_word_t word_i,
  input  logic                       word_wr_i,
  input  logic                       credit_return_i,
  output capture_pkg::capture_word_t word_o,
  output logic                       word_valid_o,
  output logic                       overflow_o
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int FW = AW + 1;
  localparam int CW = $clog2(SINK_CREDITS + 1);

  capture_pkg::capture_word_t mem [FIFO_DEPTH];
  logic [AW-1:0]              wr_ptr;
  logic [AW-1:0]              rd_ptr;
  logic [FW-1:0]              fill_cnt;
  logic [CW-1:0]              credit_cnt;
  logic                       full;
  logic                       empty;
  logic                       push;
  logic                       pop;

  // wraps at any depth, not only powers of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (fill_cnt == FW'(FIFO_DEPTH));
  assign empty = (fill_cnt == '0);
  // full is taken before this cycle's read, so a write into it is lost
  assign push  = word_wr_i & ~full;
  // one word per credit held
  assign pop   = (credit_cnt != '0) & ~empty;

  assign word_valid_o = pop;
  assign word_o       = mem[rd_ptr];

  //////////////////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem[wr_ptr] <= word_i;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // credits, return and send together cancel out
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      credit_cnt <= CW'(SINK_CREDITS);
      overflow_o <= 1'b0;
    end else begin
      case ({credit_return_i, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      // sticky until reset
      if (word_wr_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

// File: capture_top.sv
/* capture top: gate, frame builder and output FIFO */
`timescale 1ns/1ps

module capture_top #(
  parameter int ALIGN_WORDS  = 64,
  parameter int FIFO_DEPTH   = 256,
  parameter int SINK_CREDITS = 8
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  logic                       chirp_init_i,
  input  logic                       adc_enable_i,
  input  logic                       wfrm_source_i,
  input  capture_pkg::route_ctrl_t   route_ctrl_i,
  input  capture_pkg::iq_sample_t    adc_sample_i,
  input  capture_pkg::iq_sample_t    dac_sample_i,
  input  logic                       sample_valid_i,
  input  logic                       credit_return_i,
  output capture_pkg::capture_word_t word_o,
  output logic                       word_valid_o,
  output logic                       overflow_o
);

  capture_pkg::gate_ctrl_t    gate;
  capture_pkg::capture_word_t built_word;
  logic                       built_wr;
  logic                       padding;

  // latency and capture window
  capture_gate u_gate (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .chirp_init_i  (chirp_init_i),
    .adc_enable_i  (adc_enable_i),
    .wfrm_source_i (wfrm_source_i),
    .padding_i     (padding),
    .gate_o        (gate)
  );

  // words, header, trailer and padding
  frame_builder #(
    .ALIGN_WORDS (ALIGN_WORDS)
  ) u_builder (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .gate_i         (gate),
    .route_ctrl_i   (route_ctrl_i),
    .adc_sample_i   (adc_sample_i),
    .dac_sample_i   (dac_sample_i),
    .sample_valid_i (sample_valid_i),
    .word_o         (built_word),
    .word_wr_o      (built_wr),
    .padding_o      (padding)
  );

  // buffer to the credit-paced output stream
  frame_fifo #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .SINK_CREDITS (SINK_CREDITS)
  ) u_fifo (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .word_i          (built_word),
    .word_wr_i       (built_wr),
    .credit_return_i (credit_return_i),
    .word_o          (word_o),
    .word_valid_o    (word_valid_o),
    .overflow_o      (overflow_o)
  );

endmodule

// File: capture_assertions.sv
/* concurrent checks on the frame FIFO output stream for credit pacing,
   frame marker exclusion and sticky overflow, with their bind */
`timescale 1ns/1ps

module capture_assertions #(
  parameter int SINK_CREDITS = 8
) (
  input logic                       clk_245_76MHz,
  input logic                       cpu_reset,
  input logic                       credit_return_i,
  input capture_pkg::capture_word_t word_i,
  input logic                       word_valid_i,
  input logic                       overflow_i
);

  // credits the FIFO holds, rebuilt from returns and presented words
  int credits;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      credits <= SINK_CREDITS;
    end else begin
      credits <= credits + int'(credit_return_i) - int'(word_valid_i);
    end
  end

  // no word without a credit
  a_no_word_without_credit: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    word_valid_i |-> (credits > 0)
  ) else $error("word presented with the credit count at zero");

  // header and trailer are never the same word
  a_first_last_apart: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    word_valid_i |-> !(word_i.first && word_i.last)
  ) else $error("presented word has both first and last set");

  // overflow only clears through reset
  a_overflow_sticky: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    overflow_i |=> overflow_i
  ) else $error("overflow flag fell without a reset");

endmodule

bind frame_fifo capture_assertions #(
  .SINK_CREDITS (SINK_CREDITS)
) u_fifo_asrt (
  .clk_245_76MHz   (clk_245_76MHz),
  .cpu_reset       (cpu_reset),
  .credit_return_i (credit_return_i),
  .word_i          (word_o),
  .word_valid_i    (word_valid_o),
  .overflow_i      (overflow_o)
);

// File: tb_capture_top.sv
/* capture framer testbench with clock, reset, credit sink model, directed tests,
   frame checker, compare tasks and watchdog */
`timescale 1ns/1ps

module tb_capture_top;

  localparam int ALIGN_WORDS  = 16;
  localparam int FIFO_DEPTH   = 64;
  localparam int SINK_CREDITS = 4;

  // enable window of each capture in cycles
  localparam int EN_ROUTE = 24;
  localparam int EN_WFRM  = 45;
  localparam int EN_GAPS  = 33;
  localparam int EN_HOLD  = 20;
  localparam int EN_FLOOD = 100;
  // samples kept coming after enable drops so padding can finish
  localparam int TAIL_CYCLES       = 4 * ALIGN_WORDS + 8;
  localparam int QUIET_CYCLES      = 20;
  localparam int FRAME_WAIT_CYCLES = 2 * FIFO_DEPTH;
  localparam int FRAMES_EXPECTED   = 4;
  localparam int RUN_CYCLES = 8 + 3 * QUIET_CYCLES
                            + EN_ROUTE + EN_WFRM + EN_GAPS + EN_HOLD + EN_FLOOD
                            + 5 * (TAIL_CYCLES + 4)
                            + FRAMES_EXPECTED * FRAME_WAIT_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;
  localparam int RX_AW    = 10;
  localparam int RX_SLOTS = 1 << RX_AW;

  logic                       clk_245_76MHz = 1'b0;
  logic                       cpu_reset;
  logic                       chirp_init_i;
  logic                       adc_enable_i;
  logic                       wfrm_source_i;
  capture_pkg::route_ctrl_t   route_ctrl_i;
  capture_pkg::iq_sample_t    adc_sample_i;
  capture_pkg::iq_sample_t    dac_sample_i;
  logic                       sample_valid_i;
  logic                       credit_return_i = 1'b0;
  capture_pkg::capture_word_t word_o;
  logic                       word_valid_o;
  logic                       overflow_o;

  // sink model state
  capture_pkg::capture_word_t rx_mem [RX_SLOTS];
  int                         rx_total       = 0;
  int                         rx_rd          = 0;
  int                         returned_total = 0;
  int                         dut_credits    = SINK_CREDITS;
  logic                       hold_credits   = 1'b0;
  // stimulus state
  logic [31:0]                rng_state      = 32'h583d_f594;
  logic [63:0]                sent_q [$];

  capture_top #(
    .ALIGN_WORDS  (ALIGN_WORDS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .SINK_CREDITS (SINK_CREDITS)
  ) dut0 (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .chirp_init_i    (chirp_init_i),
    .adc_enable_i    (adc_enable_i),
    .wfrm_source_i   (wfrm_source_i),
    .route_ctrl_i    (route_ctrl_i),
    .adc_sample_i    (adc_sample_i),
    .dac_sample_i    (dac_sample_i),
    .sample_valid_i  (sample_valid_i),
    .credit_return_i (credit_return_i),
    .word_o          (word_o),
    .word_valid_o    (word_valid_o),
    .overflow_o      (overflow_o)
  );

  always #20 clk_245_76MHz = ~clk_245_76MHz;

  //////////////////////////////////////////////////////////////
  // reporting and compares
  //////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input capture_pkg::capture_word_t got,
                            input capture_pkg::capture_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////////////////////////////////////
  // sink receives on the falling edge and returns credits on the rising
  //////////////////////////////////////////////////////////////

  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset) begin
      if (word_valid_o) begin
        if (dut_credits == 0) begin
          abort_run("a word was presented while the sink had no credit out");
        end
        if (rx_total >= RX_SLOTS) begin
          abort_run("sink model receive buffer ran out of slots");
        end
        rx_mem[rx_total[RX_AW-1:0]] = word_o;
        rx_total = rx_total + 1;
        dut_credits = dut_credits - 1;
      end
      if (credit_return_i) begin
        dut_credits = dut_credits + 1;
      end
    end
  end

  // one credit back per received word unless held
  always @(posedge clk_245_76MHz) begin
    if (!cpu_reset && !hold_credits && (rx_total > returned_total)) begin
      credit_return_i <= 1'b1;
      returned_total = returned_total + 1;
    end else begin
      credit_return_i <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////

  // one cycle of sample input where gaps drop about a quarter of them
  task automatic feed_sample(input bit gaps);
    logic [31:0] a;
    logic [31:0] d;
    logic        v;
    rng_state = xorshift32(rng_state);
    a = rng_state;
    rng_state = xorshift32(rng_state);
    d = rng_state;
    v = gaps ? (a[1:0] != 2'b00) : 1'b1;
    adc_sample_i   <= a;
    dac_sample_i   <= d;
    sample_valid_i <= v;
    if (v) begin
      sent_q.push_back({a, d});
    end
    @(posedge clk_245_76MHz);
  endtask

  task automatic run_capture(input int en_cycles, input logic wfrm, input bit gaps);
    sent_q.delete();
    wfrm_source_i  <= wfrm;
    sample_valid_i <= 1'b0;
    // source is latched while enable is low
    repeat (2) @(posedge clk_245_76MHz);
    chirp_init_i <= 1'b1;
    adc_enable_i <= 1'b1;
    feed_sample(gaps);
    chirp_init_i <= 1'b0;
    repeat (en_cycles - 1) feed_sample(gaps);
    adc_enable_i <= 1'b0;
    repeat (TAIL_CYCLES) feed_sample(gaps);
    sample_valid_i <= 1'b0;
    @(posedge clk_245_76MHz);
  endtask

  // outputs checked mid-cycle and the task ends on a rising edge
  task automatic watch_outputs(input int cycles, input logic ovf_exp);
    repeat (cycles) begin
      @(negedge clk_245_76MHz);
      check_bit("word_valid_o", word_valid_o, 1'b0);
      check_bit("overflow_o", overflow_o, ovf_exp);
    end
    @(posedge clk_245_76MHz);
  endtask

  //////////////////////////////////////////////////////////////
  // frame checker
  //////////////////////////////////////////////////////////////

  task automatic check_frame();
    capture_pkg::capture_word_t frame [$];
    capture_pkg::capture_word_t w;
    capture_pkg::capture_word_t exp;
    logic [31:0]                lo_exp;
    int                         waited;
    int                         n;
    int                         k;
    bit                         done;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      while (rx_rd == rx_total) begin
        if (waited >= FRAME_WAIT_CYCLES) begin
          abort_run("no trailer word arrived before the frame timeout");
        end
        @(posedge clk_245_76MHz);
        waited++;
      end
      w = rx_mem[rx_rd[RX_AW-1:0]];
      rx_rd++;
      frame.push_back(w);
      done = w.last;
    end
    n = frame.size();
    if ((n < 3) || (n % ALIGN_WORDS != 0)) begin
      abort_run($sformatf("frame of %0d words is not a multiple of %0d", n, ALIGN_WORDS));
    end
    check_bit("word_o.first", frame[0].first, 1'b1);
    // payload is a run of consecutive valid samples
    k = 0;
    while ((k < sent_q.size()) && (sent_q[k] != frame[1].data)) begin
      k++;
    end
    if (k + n - 2 > sent_q.size()) begin
      abort_run("payload words do not follow the samples that were sent");
    end
    for (int i = 1; i < n - 1; i++) begin
      exp = '{data: sent_q[k + i - 1], first: 1'b0, last: 1'b0};
      check_word("word_o", frame[i], exp);
    end
    // sample count moves by one per written word
    lo_exp = frame[0].data[31:0] + 32'(n - 1);
    exp = '{data: {frame[n-1].data[63:32], lo_exp}, first: 1'b0, last: 1'b1};
    check_word("word_o", frame[n-1], exp);
    if (frame[n-1].data[63:32] <= frame[0].data[63:32]) begin
      abort_run("trailer global count is not above the header global count");
    end
  endtask

  //////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////

  task automatic test_idle();
    watch_outputs(QUIET_CYCLES, 1'b0);
  endtask

  task automatic test_route_order();
    run_capture(EN_ROUTE, 1'b0, 1'b0);
    check_frame();
  endtask

  // waveform and chirp latencies both with valid gaps
  task automatic test_alignment();
    run_capture(EN_WFRM, 1'b1, 1'b1);
    check_frame();
    run_capture(EN_GAPS, 1'b0, 1'b1);
    check_frame();
  endtask

  task automatic test_credit_hold();
    hold_credits <= 1'b1;
    run_capture(EN_HOLD, 1'b0, 1'b0);
    watch_outputs(QUIET_CYCLES, 1'b0);
    hold_credits <= 1'b0;
    check_frame();
  endtask

  // more words than FIFO plus credits
  task automatic test_overflow();
    hold_credits <= 1'b1;
    run_capture(EN_FLOOD, 1'b0, 1'b0);
    watch_outputs(QUIET_CYCLES, 1'b1);
    hold_credits <= 1'b0;
    rx_rd = rx_total;
  endtask

  initial begin
    cpu_reset      <= 1'b1;
    chirp_init_i   <= 1'b0;
    adc_enable_i   <= 1'b0;
    wfrm_source_i  <= 1'b0;
    route_ctrl_i   <= '{upper: capture_pkg::ROUTE_ADC, lower: capture_pkg::ROUTE_DAC};
    adc_sample_i   <= '0;
    dac_sample_i   <= '0;
    sample_valid_i <= 1'b0;
    repeat (8) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    test_idle();
    test_route_order();
    test_alignment();
    test_credit_hold();
    test_overflow();
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_245_76MHz);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

// File: capture_top.f
capture_pkg.sv
capture_gate.sv
frame_builder.sv
frame_fifo.sv
capture_top.sv
capture_assertions.sv
tb_capture_top.sv

// File: Makefile
# Verilator build and run of the capture framer testbench

VERILATOR ?= verilator
TOP       ?= tb_capture_top
FILELIST  ?= capture_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
